// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and instruction word width
`define CPU_WORD_W 16

// architectural register count and index width
`define CPU_REG_N 8
`define CPU_REG_W 3

// tracer sequence number width, wraps
`define CPU_SEQ_W 8

// tracer cycle stamp width, wraps
`define CPU_STAMP_W 16

`endif

// ==== design/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // basic data types
    ////////////////////////////////////////////////////////////

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_REG_W-1:0]  reg_idx_t;
    typedef logic [`CPU_SEQ_W-1:0]  seq_t;
    typedef logic [`CPU_STAMP_W-1:0] stamp_t;

    // codes 6, 7 and 12..15 are not listed and behave as nop
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_ADDI = 4'd8,
        OP_ANDI = 4'd9,
        OP_ORI  = 4'd10,
        OP_XORI = 4'd11
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // instruction formats, both 16 bits wide
    ////////////////////////////////////////////////////////////

    // register-register form
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [`CPU_WORD_W-4-3*`CPU_REG_W-1:0] unused;
    } r_fmt_t;

    // register-immediate form, imm is sign extended
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        logic [`CPU_WORD_W-4-2*`CPU_REG_W-1:0] imm;
    } i_fmt_t;

    // one word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

// ==== design/decode_stage.sv ====
module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              instr_valid,
    input  cpu_pkg::instr_u   instr,
    input  logic              ex_valid,
    input  logic              ex_we,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::word_t    ex_result,
    input  logic              rs_valid,
    input  logic              rs_we,
    input  cpu_pkg::reg_idx_t rs_rd,
    input  cpu_pkg::word_t    rs_data,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    output logic              dec_valid,
    output cpu_pkg::opcode_e  dec_op,
    output logic              dec_we,
    output cpu_pkg::reg_idx_t dec_rd,
    output cpu_pkg::word_t    dec_a,
    output cpu_pkg::word_t    dec_b
);

    ////////////////////////////////////////////////////////////
    // format decode of the incoming word
    ////////////////////////////////////////////////////////////

    logic           is_r_fmt;
    logic           is_i_fmt;
    cpu_pkg::word_t imm_ext;

    always_comb begin
        is_r_fmt = 1'b0;
        is_i_fmt = 1'b0;
        case (instr.r.opcode)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT: is_r_fmt = 1'b1;
            cpu_pkg::OP_ADDI, cpu_pkg::OP_ANDI,
            cpu_pkg::OP_ORI, cpu_pkg::OP_XORI:                 is_i_fmt = 1'b1;
            default: ;
        endcase
    end

    // signed size cast does the sign extension
    assign imm_ext = cpu_pkg::word_t'(signed'(instr.i.imm));

    ////////////////////////////////////////////////////////////
    // decode pipeline register
    ////////////////////////////////////////////////////////////

    cpu_pkg::reg_idx_t dec_rs1;
    cpu_pkg::reg_idx_t dec_rs2;
    cpu_pkg::word_t    dec_imm;
    logic              dec_use_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_we    <= 1'b0;
        end else if (advance) begin
            dec_valid <= instr_valid;
            // nop and writes to r0 never update state
            dec_we    <= instr_valid && (is_r_fmt || is_i_fmt) && (instr.r.rd != '0);
        end
    end

    // payload, don't care while the slot is empty
    always_ff @(posedge clk) begin
        if (advance) begin
            dec_op      <= instr.r.opcode;
            dec_rd      <= instr.r.rd;
            dec_rs1     <= instr.r.rs1;
            dec_rs2     <= instr.r.rs2;
            dec_imm     <= imm_ext;
            dec_use_imm <= is_i_fmt;
        end
    end

    ////////////////////////////////////////////////////////////
    // operand read and forwarding
    ////////////////////////////////////////////////////////////

    cpu_pkg::word_t rf_a;
    cpu_pkg::word_t rf_b;

    register_file register_file_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (dec_rs1),
        .rd_addr_b (dec_rs2),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (wb_en),
        .wr_addr   (wb_rd),
        .wr_data   (wb_data)
    );

    // youngest older instruction wins
    // execute slot is one behind, result slot is two behind
    function automatic cpu_pkg::word_t fwd(input cpu_pkg::reg_idx_t idx,
                                           input cpu_pkg::word_t rf_val);
        cpu_pkg::word_t val;
        if (ex_valid && ex_we && (ex_rd == idx)) begin
            val = ex_result;
        end else if (rs_valid && rs_we && (rs_rd == idx)) begin
            val = rs_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    // a retire write in this cycle is already covered by the result slot
    always_comb begin
        dec_a = fwd(dec_rs1, rf_a);
        dec_b = dec_use_imm ? dec_imm : fwd(dec_rs2, rf_b);
    end

endmodule

// ==== design/execute_stage.sv ====
module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              dec_valid,
    input  cpu_pkg::opcode_e  dec_op,
    input  logic              dec_we,
    input  cpu_pkg::reg_idx_t dec_rd,
    input  cpu_pkg::word_t    dec_a,
    input  cpu_pkg::word_t    dec_b,
    output logic              ex_valid,
    output logic              ex_we,
    output cpu_pkg::reg_idx_t ex_rd,
    output cpu_pkg::word_t    ex_result
);

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    cpu_pkg::word_t alu_out;

    // immediate forms share the register datapath, b already holds imm
    always_comb begin
        case (dec_op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI: alu_out = dec_a + dec_b;
            cpu_pkg::OP_SUB:                   alu_out = dec_a - dec_b;
            cpu_pkg::OP_AND, cpu_pkg::OP_ANDI: alu_out = dec_a & dec_b;
            cpu_pkg::OP_OR,  cpu_pkg::OP_ORI:  alu_out = dec_a | dec_b;
            cpu_pkg::OP_XOR, cpu_pkg::OP_XORI: alu_out = dec_a ^ dec_b;
            // signed compare, result is 0 or 1
            cpu_pkg::OP_SLT: alu_out = cpu_pkg::word_t'($signed(dec_a) < $signed(dec_b));
            default:         alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // execute pipeline register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
        end else if (advance) begin
            ex_valid <= dec_valid;
            ex_we    <= dec_valid && dec_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rd     <= dec_rd;
            ex_result <= alu_out;
        end
    end

endmodule

// ==== design/pipe_core.sv ====
module pipe_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  cpu_pkg::instr_u   instr,
    output logic              instr_ready,
    output logic              retire_valid,
    input  logic              retire_ready,
    output logic              retire_we,
    output cpu_pkg::reg_idx_t retire_rd,
    output cpu_pkg::word_t    retire_data,
    output cpu_pkg::seq_t     retire_seq,
    output cpu_pkg::stamp_t   retire_accept_cycle,
    output cpu_pkg::stamp_t   retire_cycle
);

    ////////////////////////////////////////////////////////////
    // pipeline control
    ////////////////////////////////////////////////////////////

    logic advance;
    logic accept;

    // whole pipe moves together, only back-pressure from retire stalls it
    assign advance     = retire_ready || !retire_valid;
    assign instr_ready = advance;
    assign accept      = instr_valid && advance;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    logic              dec_valid;
    cpu_pkg::opcode_e  dec_op;
    logic              dec_we;
    cpu_pkg::reg_idx_t dec_rd;
    cpu_pkg::word_t    dec_a;
    cpu_pkg::word_t    dec_b;

    logic              ex_valid;
    logic              ex_we;
    cpu_pkg::reg_idx_t ex_rd;
    cpu_pkg::word_t    ex_result;

    logic              wb_en;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    // result slot doubles as the older forwarding source
    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex_valid    (ex_valid),
        .ex_we       (ex_we),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .rs_valid    (retire_valid),
        .rs_we       (retire_we),
        .rs_rd       (retire_rd),
        .rs_data     (retire_data),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_we      (dec_we),
        .dec_rd      (dec_rd),
        .dec_a       (dec_a),
        .dec_b       (dec_b)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_we    (dec_we),
        .dec_rd    (dec_rd),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .ex_valid  (ex_valid),
        .ex_we     (ex_we),
        .ex_rd     (ex_rd),
        .ex_result (ex_result)
    );

    result_stage result_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .ex_valid     (ex_valid),
        .ex_we        (ex_we),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // trace
    ////////////////////////////////////////////////////////////

    pipeline_tracer pipeline_tracer_inst (
        .clk                 (clk),
        .rst                 (rst),
        .accept              (accept),
        .advance             (advance),
        .retire_seq          (retire_seq),
        .retire_accept_cycle (retire_accept_cycle),
        .retire_cycle        (retire_cycle)
    );

endmodule

// ==== design/pipeline_tracer.sv ====
module pipeline_tracer (
    input  logic            clk,
    input  logic            rst,
    input  logic            accept,
    input  logic            advance,
    output cpu_pkg::seq_t   retire_seq,
    output cpu_pkg::stamp_t retire_accept_cycle,
    output cpu_pkg::stamp_t retire_cycle
);

    ////////////////////////////////////////////////////////////
    // free running counters
    ////////////////////////////////////////////////////////////

    cpu_pkg::seq_t   seq_cnt;
    cpu_pkg::stamp_t cycle_cnt;

    // cycle 0 is the first cycle after reset, both counters wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            seq_cnt   <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shadow slots for decode, execute and result
    ////////////////////////////////////////////////////////////

    cpu_pkg::seq_t   slot_seq   [3];
    cpu_pkg::stamp_t slot_stamp [3];

    // id and accept stamp follow the instruction stage to stage
    // slot 0 is loaded on every advance, an empty slot carries junk
    always_ff @(posedge clk) begin
        if (advance) begin
            slot_seq[0]   <= seq_cnt;
            slot_stamp[0] <= cycle_cnt;
            for (int i = 1; i < 3; i++) begin
                slot_seq[i]   <= slot_seq[i-1];
                slot_stamp[i] <= slot_stamp[i-1];
            end
        end
    end

    // result slot beside the retiring payload
    assign retire_seq          = slot_seq[2];
    assign retire_accept_cycle = slot_stamp[2];

    // live count, retire cycle is the cycle the record is shown
    assign retire_cycle = cycle_cnt;

endmodule

// ==== design/register_file.sv ====
`include "cpu_macros.svh"

module register_file (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::reg_idx_t rd_addr_a,
    input  cpu_pkg::reg_idx_t rd_addr_b,
    output cpu_pkg::word_t   rd_data_a,
    output cpu_pkg::word_t   rd_data_b,
    input  logic             wr_en,
    input  cpu_pkg::reg_idx_t wr_addr,
    input  cpu_pkg::word_t   wr_data
);

    cpu_pkg::word_t regs [`CPU_REG_N];

    // single write port, r0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, r0 forced to zero
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// ==== design/result_stage.sv ====
module result_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              ex_valid,
    input  logic              ex_we,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::word_t    ex_result,
    input  logic              retire_ready,
    output logic              retire_valid,
    output logic              retire_we,
    output cpu_pkg::reg_idx_t retire_rd,
    output cpu_pkg::word_t    retire_data,
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data
);

    // result slot, held while retire is stalled since advance stays low
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else if (advance) begin
            retire_valid <= ex_valid;
            retire_we    <= ex_valid && ex_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            retire_rd   <= ex_rd;
            retire_data <= ex_result;
        end
    end

    ////////////////////////////////////////////////////////////
    // register file write back
    ////////////////////////////////////////////////////////////

    // write only on the retire handshake
    assign wb_en   = retire_valid && retire_ready && retire_we;
    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

// ==== files.f ====
+incdir+design
design/cpu_pkg.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/pipeline_tracer.sv
design/pipe_core.sv
tests/pipe_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the pipe_core testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module pipe_core_tb -f files.f -o pipe_core_sim

./obj_dir/pipe_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi

// ==== tests/pipe_core_golden.txt ====
# T <test> opens a group, I <instr hex> is one instruction word
# R <we> <rd> <data hex> <seq hex> is the next expected retire record
T 2
I 8205  addi r1, r0, 5
I 843d  addi r2, r0, -3
I 5888  slt  r4, r2, r1
I b04f  xori r0, r1, 15
I 0e10  add  r7, r0, r2
R 1 1 0005 00
R 1 2 fffd 01
R 1 4 0001 02
R 0 0 000a 03
R 1 7 fffd 04
T 3
I 8647  addi r3, r1, 7
I 1ac8  sub  r5, r3, r1
I 4ce8  xor  r6, r3, r5
I 32f0  or   r1, r3, r6
R 1 3 000c 05
R 1 5 0007 06
R 1 6 000b 07
R 1 1 000f 08
T 4
I 949e  andi r2, r2, 30
I 08a8  add  r4, r2, r5
I 2b08  and  r5, r4, r1
I f000  nop
R 1 2 001c 09
R 1 4 0023 0a
R 1 5 0003 0b
R 0 0 0000 0c
T 5
I bd3f  xori r6, r4, -1
I 5f80  slt  r7, r6, r0
I 1630  sub  r3, r0, r6
R 1 6 ffdc 0d
R 1 7 0001 0e
R 1 3 0024 0f
T 6
I a2d0  ori  r1, r3, 16
I 0448  add  r2, r1, r1
I 4898  xor  r4, r2, r3
R 1 1 0034 10
R 1 2 0068 11
R 1 4 004c 12

// ==== tests/pipe_core_tb.sv ====
module pipe_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // dut signals
    ////////////////////////////////////////////////////////////

    logic              clk = 1'b0;
    logic              rst;
    logic              instr_valid;
    cpu_pkg::instr_u   instr;
    logic              instr_ready;
    logic              retire_valid;
    logic              retire_ready = 1'b1;
    logic              retire_we;
    cpu_pkg::reg_idx_t retire_rd;
    cpu_pkg::word_t    retire_data;
    cpu_pkg::seq_t     retire_seq;
    cpu_pkg::stamp_t   retire_accept_cycle;
    cpu_pkg::stamp_t   retire_cycle;

    pipe_core pipe_core_inst (
        .clk                 (clk),
        .rst                 (rst),
        .instr_valid         (instr_valid),
        .instr               (instr),
        .instr_ready         (instr_ready),
        .retire_valid        (retire_valid),
        .retire_ready        (retire_ready),
        .retire_we           (retire_we),
        .retire_rd           (retire_rd),
        .retire_data         (retire_data),
        .retire_seq          (retire_seq),
        .retire_accept_cycle (retire_accept_cycle),
        .retire_cycle        (retire_cycle)
    );

    // 8 ns period
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // golden records and run state
    ////////////////////////////////////////////////////////////

    typedef struct {
        int             test;
        cpu_pkg::word_t word;
    } prog_rec_t;

    typedef struct {
        int                test;
        logic              we;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    data;
        cpu_pkg::seq_t     seq;
    } exp_rec_t;

    prog_rec_t prog_q[$];
    exp_rec_t  exp_q[$];

    int errors;
    int tests_passed;
    int tests_failed;
    int cur_test;
    bit bp_on;

    // retire monitor state
    logic              held;
    logic              held_we;
    cpu_pkg::reg_idx_t held_rd;
    cpu_pkg::word_t    held_data;
    cpu_pkg::seq_t     held_seq;
    cpu_pkg::stamp_t   held_stamp;
    logic              have_stamp;
    cpu_pkg::stamp_t   last_stamp;

    ////////////////////////////////////////////////////////////
    // compare tasks for each result type
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0d ns %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_seq(input string name, input cpu_pkg::seq_t got,
                             input cpu_pkg::seq_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0d ns %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_stamp(input string name, input cpu_pkg::stamp_t got,
                               input cpu_pkg::stamp_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0d ns %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input cpu_pkg::reg_idx_t got,
                             input cpu_pkg::reg_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0d ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0d ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // golden file reader
    ////////////////////////////////////////////////////////////

    task automatic load_golden();
        int                fd;
        int                t;
        int                cur;
        string             line;
        cpu_pkg::word_t    w;
        logic              we;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    data;
        cpu_pkg::seq_t     seq;
        prog_rec_t         p;
        exp_rec_t          e;
        fd = $fopen("tests/pipe_core_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/pipe_core_golden.txt");
            return;
        end
        cur = 0;
        // T opens a group, I is an instruction, R an expected retire
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "T %d", t) == 1) begin
                cur = t;
            end else if ($sscanf(line, "I %h", w) == 1) begin
                p.test = cur;
                p.word = w;
                prog_q.push_back(p);
            end else if ($sscanf(line, "R %d %d %h %h", we, rd, data, seq) == 4) begin
                e.test = cur;
                e.we   = we;
                e.rd   = rd;
                e.data = data;
                e.seq  = seq;
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // roughly 30% stall cycles while back-pressure is on
    always @(posedge clk) begin
        if (bp_on) begin
            retire_ready <= (($urandom % 100) >= 30);
        end else begin
            retire_ready <= 1'b1;
        end
    end

    // one word per handshake and held until accepted
    task automatic drive_test(input int num);
        while (prog_q.size() > 0 && prog_q[0].test == num) begin
            instr_valid <= 1'b1;
            instr       <= cpu_pkg::instr_u'(prog_q[0].word);
            prog_q.delete(0);
            @(posedge clk);
            while (!instr_ready) begin
                @(posedge clk);
            end
        end
        instr_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // retire monitor
    ////////////////////////////////////////////////////////////

    task automatic compare_retire();
        exp_rec_t rec;
        if (exp_q.size() == 0) begin
            errors++;
            $display("retire at t=%0d ns with no golden record left", $time);
        end else begin
            rec = exp_q.pop_front();
            check_bit("retire_we", retire_we, rec.we);
            check_idx("retire_rd", retire_rd, rec.rd);
            check_word("retire_data", retire_data, rec.data);
            check_seq("retire_seq", retire_seq, rec.seq);
        end
        // accept stamps rise strictly in program order
        if (have_stamp && (retire_accept_cycle <= last_stamp)) begin
            errors++;
            $display("accept stamp 0x%h at t=%0d ns is not above the previous 0x%h",
                     retire_accept_cycle, $time, last_stamp);
        end
        have_stamp = 1'b1;
        last_stamp = retire_accept_cycle;
        // three stages and no stall in between
        if (cur_test == 6) begin
            check_stamp("retire_cycle-retire_accept_cycle",
                        retire_cycle - retire_accept_cycle, cpu_pkg::stamp_t'(3));
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            held       = 1'b0;
            have_stamp = 1'b0;
        end else begin
            // stalled payload must not move
            if (held) begin
                check_bit("retire_valid", retire_valid, 1'b1);
                check_bit("retire_we", retire_we, held_we);
                check_idx("retire_rd", retire_rd, held_rd);
                check_word("retire_data", retire_data, held_data);
                check_seq("retire_seq", retire_seq, held_seq);
                check_stamp("retire_accept_cycle", retire_accept_cycle, held_stamp);
            end
            if (retire_valid && retire_ready) begin
                compare_retire();
            end
            held       = retire_valid && !retire_ready;
            held_we    = retire_we;
            held_rd    = retire_rd;
            held_data  = retire_data;
            held_seq   = retire_seq;
            held_stamp = retire_accept_cycle;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequencing
    ////////////////////////////////////////////////////////////

    task automatic report_test(input int num, input string title, input int mark);
        if (errors == mark) begin
            tests_passed++;
            $display("test %0d %s: passed", num, title);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, title, errors - mark);
        end
    endtask

    task automatic run_test(input int num, input string title);
        int mark;
        mark     = errors;
        cur_test = num;
        bp_on    <= (num == 4) || (num == 5);
        drive_test(num);
        // drain every record of this group
        while (exp_q.size() > 0 && exp_q[0].test == num) begin
            @(negedge clk);
        end
        bp_on <= 1'b0;
        repeat (2) @(posedge clk);
        report_test(num, title, mark);
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout after %0d cycles, retire records still missing", cycles);
        $display("Result: FAILED");
        $finish;
    endtask

    initial begin
        int mark;
        void'($urandom(32'hb0a2c76b));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cur_test    = 0;
        load_golden();
        if (exp_q.size() == 0) begin
            errors++;
            $display("golden file holds no retire records");
        end
        fork
            watchdog(prog_q.size() * 40 + 200);
        join_none
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // pipe is empty and open right after reset
        mark     = errors;
        cur_test = 1;
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("instr_ready", instr_ready, 1'b1);
        report_test(1, "after reset", mark);
        run_test(2, "both formats");
        run_test(3, "forwarding");
        run_test(4, "random back-pressure");
        run_test(5, "sequence numbering");
        run_test(6, "latency");
        if (prog_q.size() != 0 || exp_q.size() != 0) begin
            errors++;
            $display("golden lines outside tests 2 to 6 were never used");
        end
        $display("tests %0d passed %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
